// File: vlog.f
+incdir+verilog
verilog/sys_io_pkg.sv
verilog/cmd_decoder.sv
verilog/aud_mix.sv
verilog/sync_fix.sv
verilog/csync_gen.sv
verilog/sys_io_top.sv
verif/sys_io_asserts.sv
verif/sys_io_checker.sv
verif/tb_sys_io.sv

// File: run.sh
#!/bin/bash
# Builds the testbench with Verilator and runs it from the project root
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_sys_io \
	-f vlog.f

output=$(./obj_dir/Vtb_sys_io)
echo "$output"

if grep -q "Finished with no errors" <<< "$output"; then
	exit 0
else
	exit 1
fi

// File: verif/tb_sys_io.sv
// Runs one fixed-seed sequence; the sync generator needs a line longer than twice the pulse width
`timescale 1ns/1ps
`include "sys_io_defines.svh"

module tb_sys_io;
	import sys_io_pkg::*;

	localparam int CLK_PERIOD   = 40;
	localparam int LINE_LEN     = 20;
	localparam int HS_W         = 3;
	localparam int FRAME_LINES  = 8;
	localparam int VS_LINES     = 2;
	localparam int FRAME_CYCLES = LINE_LEN * FRAME_LINES;
	localparam int WR_CYCLES    = 6;
	localparam int AUD_SETTLE   = 10;
	localparam int STIM_CYCLES  = 20 + 12 * (WR_CYCLES + 2) + 24 * (AUD_SETTLE + 2)
		+ 6 * (WR_CYCLES + AUD_SETTLE + 2) + 6 * FRAME_CYCLES + 2 * WR_CYCLES + 20;

	logic              clk;
	logic              resetd;
	io_bus_t           io;
	status_led_t       status;
	audio_pair_t       core_audio;
	audio_pair_t       pcm;
	logic [1:0]        audio_mix;
	logic              audio_signed;
	sync_t             sync_in;
	logic [7:0]        led;
	cfg_word_t         cfg;
	audio_pair_t       audio;
	sync_t             sync_out;
	int                hpos  = 0;
	int                vline = 0;
	logic              chk_req;
	logic              chk_audio;
	logic              test_end;
	logic [3:0]        test_id;
	logic              all_done;
	logic              sync_chk;
	cfg_word_t         exp_cfg;
	logic [7:0]        exp_ovr;
	logic [7:0]        exp_state;
	logic [`ATT_W-1:0] exp_att;
	int                errors;

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	sys_io_top u_dut (
		.clk            (clk),
		.resetd         (resetd),
		.i_io           (io),
		.i_status       (status),
		.i_core_audio   (core_audio),
		.i_pcm          (pcm),
		.i_audio_mix    (audio_mix),
		.i_audio_signed (audio_signed),
		.i_sync         (sync_in),
		.o_led          (led),
		.o_cfg          (cfg),
		.o_audio        (audio),
		.o_sync         (sync_out)
	);

	sys_io_checker #(.LINE_LEN(LINE_LEN), .HS_W(HS_W)) u_chk (
		.clk (clk), .i_req (chk_req), .i_audio_kind (chk_audio), .i_end (test_end),
		.i_test (test_id), .i_done (all_done), .i_sync_chk (sync_chk),
		.i_exp_cfg (exp_cfg), .i_exp_ovr (exp_ovr), .i_exp_state (exp_state),
		.i_exp_att (exp_att), .i_status (status), .i_core (core_audio), .i_pcm (pcm),
		.i_mix (audio_mix), .i_signed (audio_signed), .i_sync (sync_in), .i_hpos (hpos),
		.i_led (led), .i_cfg (cfg), .i_audio (audio), .i_osync (sync_out),
		.o_errors (errors)
	);

	bind cmd_decoder sys_io_asserts #(.DEC_CHK(1'b1)) u_dec_asrt (
		.clk (clk), .resetd (resetd), .i_strobe_rise (strobe_rise), .i_att (att_q),
		.i_cfg (cfg_q), .i_vs_in (1'b0), .i_vs_out (1'b0)
	);

	bind csync_gen sys_io_asserts #(.DEC_CHK(1'b0)) u_cs_asrt (
		.clk (clk), .resetd (resetd), .i_strobe_rise (1'b0), .i_att (5'd0),
		.i_cfg (16'h0000), .i_vs_in (i_sync.vs), .i_vs_out (o_sync.vs)
	);

	////////////////////////////////////////
	// Active-low sync, free running
	////////////////////////////////////////

	always @(negedge clk) begin
		if (hpos == LINE_LEN - 1) begin
			hpos  <= 0;
			vline <= (vline == FRAME_LINES - 1) ? 0 : vline + 1;
		end else begin
			hpos <= hpos + 1;
		end
	end

	assign sync_in.hs = (hpos >= HS_W);
	assign sync_in.vs = (vline >= VS_LINES);

	////////////////////////////////////////
	// Stimulus helpers
	////////////////////////////////////////

	task automatic write_cmd(input logic [7:0] code, input logic [`IO_W-1:0] data);
		@(negedge clk);
		io.sel_uio = 1'b1;
		io.strobe  = 1'b1;
		io.din     = {8'h00, code};
		@(negedge clk);
		io.strobe = 1'b0;
		@(negedge clk);
		io.strobe = 1'b1;
		io.din    = data;
		@(negedge clk);
		io.strobe = 1'b0;
		@(negedge clk);
		io.sel_uio = 1'b0;
		@(negedge clk);
	endtask

	task automatic check_now(input logic audio_kind);
		@(negedge clk);
		chk_audio = audio_kind;
		chk_req   = 1'b1;
		@(negedge clk);
		chk_req = 1'b0;
	endtask

	task automatic end_test(input int id);
		@(negedge clk);
		test_id  = id[3:0];
		test_end = 1'b1;
		@(negedge clk);
		test_end = 1'b0;
	endtask

	// Full-scale samples on both channels saturate the sum
	task automatic hold_audio(input logic [1:0] mode, input logic sgn, input logic sat);
		@(negedge clk);
		audio_mix    = mode;
		audio_signed = sgn;
		if (sat) begin
			core_audio = '{l: 16'h7fff, r: 16'h8000};
			pcm        = '{l: 16'h7fff, r: 16'h8000};
		end else begin
			core_audio = '{l: 16'($urandom), r: 16'($urandom)};
			pcm        = '{l: 16'($urandom), r: 16'($urandom)};
		end
		repeat (AUD_SETTLE) @(negedge clk);
		check_now(1'b1);
	endtask

	initial begin
		#(2 * STIM_CYCLES * CLK_PERIOD);
		$display("watchdog expired before the tests completed");
		$display("Finished with errors");
		$finish;
	end

	////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////

	initial begin
		logic [`IO_W-1:0]  word;
		logic [`ATT_W-1:0] att;
		void'($urandom(32'h41f20871));
		resetd = 1'b1;
		io = '0;
		status = '0;
		core_audio = '0;
		pcm = '0;
		audio_mix = 2'd0;
		audio_signed = 1'b0;
		chk_req = 1'b0;
		chk_audio = 1'b0;
		test_end = 1'b0;
		test_id = 4'd0;
		all_done = 1'b0;
		sync_chk = 1'b0;
		exp_cfg = '0;
		exp_ovr = 8'h00;
		exp_state = 8'h00;
		exp_att = '0;
		repeat (5) @(negedge clk);
		resetd = 1'b0;

		status = 5'($urandom);
		check_now(1'b0);
		end_test(1);

		for (int i = 0; i < 4; i++) begin
			word = 16'($urandom);
			write_cmd(`CMD_CFG, word);
			exp_cfg = word;
			check_now(1'b0);
		end
		for (int i = 0; i < 4; i++) begin
			word = 16'($urandom);
			write_cmd(`CMD_LED, word);
			exp_ovr   = word[15:8];
			exp_state = word[7:0];
			check_now(1'b0);
			status = 5'($urandom);
			check_now(1'b0);
		end
		// Unknown command leaves every register alone
		write_cmd(8'h33, 16'($urandom));
		check_now(1'b0);
		end_test(2);

		for (int m = 0; m < 4; m++) begin
			for (int s = 0; s < 2; s++) begin
				for (int k = 0; k < 3; k++) begin
					hold_audio(2'(m), 1'(s), k == 2);
				end
			end
		end
		end_test(3);

		for (int i = 0; i < 6; i++) begin
			att = {(i >= 4), 4'($urandom)};
			write_cmd(`CMD_VOL, {11'd0, att});
			exp_att = att;
			hold_audio(2'($urandom), 1'($urandom), i == 3);
		end
		end_test(4);

		write_cmd(`CMD_CFG, 16'h0000);
		exp_cfg = '0;
		repeat (FRAME_CYCLES) @(negedge clk);
		sync_chk = 1'b1;
		repeat (2 * FRAME_CYCLES) @(negedge clk);
		sync_chk = 1'b0;
		end_test(5);

		// Bit 3 enables composite sync
		write_cmd(`CMD_CFG, 16'h0008);
		exp_cfg = 16'h0008;
		repeat (LINE_LEN) @(negedge clk);
		sync_chk = 1'b1;
		repeat (2 * FRAME_CYCLES) @(negedge clk);
		sync_chk = 1'b0;
		check_now(1'b0);
		end_test(6);

		@(negedge clk);
		all_done = 1'b1;
		@(negedge clk);
		all_done = 1'b0;
		@(negedge clk);
		if (errors == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

// File: verif/sys_io_checker.sv
// Samples on the rising edge, so stimulus must change only on the falling edge; sync timing is fixed
`timescale 1ns/1ps
`include "sys_io_defines.svh"

module sys_io_checker #(
	parameter int LINE_LEN = 20,
	parameter int HS_W     = 3
) (
	input  logic                    clk,
	input  logic                    i_req,
	input  logic                    i_audio_kind,
	input  logic                    i_end,
	input  logic [3:0]              i_test,
	input  logic                    i_done,
	input  logic                    i_sync_chk,
	input  sys_io_pkg::cfg_word_t   i_exp_cfg,
	input  logic [7:0]              i_exp_ovr,
	input  logic [7:0]              i_exp_state,
	input  logic [`ATT_W-1:0]       i_exp_att,
	input  sys_io_pkg::status_led_t i_status,
	input  sys_io_pkg::audio_pair_t i_core,
	input  sys_io_pkg::audio_pair_t i_pcm,
	input  logic [1:0]              i_mix,
	input  logic                    i_signed,
	input  sys_io_pkg::sync_t       i_sync,
	input  int                      i_hpos,
	input  logic [7:0]              i_led,
	input  sys_io_pkg::cfg_word_t   i_cfg,
	input  sys_io_pkg::audio_pair_t i_audio,
	input  sys_io_pkg::sync_t       i_osync,
	output int                      o_errors
);
	import sys_io_pkg::*;

	int    err_cnt   = 0;
	int    test_err  = 0;
	int    check_cnt = 0;
	sync_t sync_d    = '0;
	int    hpos_d    = 0;

	assign o_errors = err_cnt;

	////////////////////////////////////////
	// Reference model
	////////////////////////////////////////

	function automatic logic [7:0] ref_led(status_led_t st, logic [7:0] ovr, logic [7:0] state);
		logic [7:0] dflt;
		dflt    = 8'h00;
		dflt[0] = st.user;
		dflt[2] = st.disk[0];
		dflt[4] = (st.power == 2'b11);
		return (ovr & state) | (~ovr & dflt);
	endfunction

	// Core plus PCM, unsigned core is halved first
	function automatic int first_sum(logic [15:0] core, logic [15:0] pcm, logic sgn);
		int c;
		if (sgn) begin
			c = int'($signed(core));
		end else begin
			c = int'(core >> 1);
		end
		return c + int'($signed(pcm));
	endfunction

	function automatic logic [15:0] ref_audio(logic [15:0] core, logic [15:0] pcm,
			logic [15:0] other_core, logic [15:0] other_pcm, logic [1:0] mix, logic sgn,
			logic [4:0] att);
		int s;
		int p;
		int b;
		s = first_sum(core, pcm, sgn);
		p = first_sum(other_core, other_pcm, sgn) >>> 1;
		case (mix)
			2'd0: b = s;
			2'd1: b = s - (s >>> 3) + (p >>> 2);
			2'd2: b = s - (s >>> 2) + (p >>> 1);
			default: b = (s >>> 1) + p;
		endcase
		if (att[4]) begin
			b = 0;
		end else begin
			b = b >>> att[3:0];
		end
		if (b > 32767) begin
			b = 32767;
		end else if (b < -32768) begin
			b = -32768;
		end
		return 16'(b);
	endfunction

	// Composite pulse sits in the last HS_W cycles of each line during vsync
	function automatic logic ref_hs(int pos, logic vs_act, logic en);
		if (vs_act && en) begin
			return pos >= LINE_LEN - HS_W;
		end else begin
			return pos < HS_W;
		end
	endfunction

	function automatic string test_name(logic [3:0] id);
		case (id)
			4'd1: return "reset defaults";
			4'd2: return "config and LED commands";
			4'd3: return "audio mix modes";
			4'd4: return "attenuation and mute";
			4'd5: return "sync polarity";
			4'd6: return "composite sync";
			default: return "unknown";
		endcase
	endfunction

	task automatic compare(string name, logic [15:0] got, logic [15:0] exp);
		check_cnt++;
		if (got !== exp) begin
			$display("mismatch %s: got %h expected %h at %0t", name, got, exp, $time);
			err_cnt++;
		end
	endtask

	////////////////////////////////////////
	// Comparison
	////////////////////////////////////////

	always @(posedge clk) begin
		logic hs_exp;
		if (i_req) begin
			if (!i_audio_kind) begin
				compare("o_cfg", i_cfg, i_exp_cfg);
				compare("o_led", {8'h00, i_led},
					{8'h00, ref_led(i_status, i_exp_ovr, i_exp_state)});
			end else begin
				compare("o_audio.l", i_audio.l, ref_audio(i_core.l, i_pcm.l, i_core.r,
					i_pcm.r, i_mix, i_signed, i_exp_att));
				compare("o_audio.r", i_audio.r, ref_audio(i_core.r, i_pcm.r, i_core.l,
					i_pcm.l, i_mix, i_signed, i_exp_att));
			end
		end

		// Outputs now show the inputs of the previous edge
		if (i_sync_chk) begin
			hs_exp = ref_hs(hpos_d, !sync_d.vs, i_exp_cfg.csync_en);
			compare("o_sync.hs", {15'd0, i_osync.hs}, {15'd0, hs_exp});
			compare("o_sync.vs", {15'd0, i_osync.vs}, {15'd0, !sync_d.vs});
		end
		sync_d = i_sync;
		hpos_d = i_hpos;

		if (i_end) begin
			$display("test %0d %s: %s, %0d errors", i_test, test_name(i_test),
				(err_cnt == test_err) ? "passed" : "failed", err_cnt - test_err);
			test_err = err_cnt;
		end
		if (i_done) begin
			$display("tests complete: %0d checks, %0d errors", check_cnt, err_cnt);
		end
	end

endmodule

// File: verif/sys_io_asserts.sv
// Bound into cmd_decoder and csync_gen; DEC_CHK selects the decoder or the sync assertions
`timescale 1ns/1ps
`include "sys_io_defines.svh"

module sys_io_asserts #(
	parameter bit DEC_CHK = 1'b1
) (
	input logic              clk,
	input logic              resetd,
	input logic              i_strobe_rise,
	input logic [`ATT_W-1:0] i_att,
	input logic [`IO_W-1:0]  i_cfg,
	input logic              i_vs_in,
	input logic              i_vs_out
);

	generate
		if (DEC_CHK) begin : g_dec

			////////////////////////////////////////
			// Decoder registers
			////////////////////////////////////////

			a_att_stable: assert property (@(posedge clk) disable iff (resetd)
				!i_strobe_rise |=> $stable(i_att))
				else $error("attenuation changed without a strobe edge");

			a_cfg_stable: assert property (@(posedge clk) disable iff (resetd)
				!i_strobe_rise |=> $stable(i_cfg))
				else $error("configuration changed without a strobe edge");

		end else begin : g_sync

			////////////////////////////////////////
			// Sync path
			////////////////////////////////////////

			// Vsync is registered once, no other change
			a_vs_follow: assert property (@(posedge clk) disable iff (resetd)
				!$past(resetd) |-> (i_vs_out == $past(i_vs_in)))
				else $error("vsync output does not follow the fixed vsync one cycle later");

		end
	endgenerate

endmodule

// File: verilog/sys_io_top.sv
// Single clock domain; all inputs must already be synchronous to clk, there is no back-pressure
`timescale 1ns/1ps
`include "sys_io_defines.svh"

module sys_io_top (
	input  logic                      clk,
	input  logic                      resetd,
	input  sys_io_pkg::io_bus_t       i_io,
	input  sys_io_pkg::status_led_t   i_status,
	input  sys_io_pkg::audio_pair_t   i_core_audio,
	input  sys_io_pkg::audio_pair_t   i_pcm,
	input  logic [1:0]                i_audio_mix,
	input  logic                      i_audio_signed,
	input  sys_io_pkg::sync_t         i_sync,
	output logic [7:0]                o_led,
	output sys_io_pkg::cfg_word_t     o_cfg,
	output sys_io_pkg::audio_pair_t   o_audio,
	output sys_io_pkg::sync_t         o_sync
);
	import sys_io_pkg::*;

	logic              csync_en;
	logic [`ATT_W-1:0] att;
	logic [`AUD_W-1:0] pre_l;
	logic [`AUD_W-1:0] pre_r;
	logic [`AUD_W-1:0] out_l;
	logic [`AUD_W-1:0] out_r;
	logic              hs_fixed;
	logic              vs_fixed;
	sync_t             sync_fixed;

	////////////////////////////////////////
	// Host command decoder
	////////////////////////////////////////

	cmd_decoder u_cmd (
		.clk        (clk),
		.resetd     (resetd),
		.i_io       (i_io),
		.i_status   (i_status),
		.o_cfg      (o_cfg),
		.o_csync_en (csync_en),
		.o_att      (att),
		.o_led      (o_led)
	);

	////////////////////////////////////////
	// Audio, pre-mix words cross-coupled
	////////////////////////////////////////

	aud_mix u_mix_l (
		.clk      (clk),
		.resetd   (resetd),
		.i_core   (i_core_audio.l),
		.i_pcm    (i_pcm.l),
		.i_pre    (pre_r),
		.i_mix    (i_audio_mix),
		.i_signed (i_audio_signed),
		.i_att    (att),
		.o_pre    (pre_l),
		.o_out    (out_l)
	);

	aud_mix u_mix_r (
		.clk      (clk),
		.resetd   (resetd),
		.i_core   (i_core_audio.r),
		.i_pcm    (i_pcm.r),
		.i_pre    (pre_l),
		.i_mix    (i_audio_mix),
		.i_signed (i_audio_signed),
		.i_att    (att),
		.o_pre    (pre_r),
		.o_out    (out_r)
	);

	assign o_audio = '{l: out_l, r: out_r};

	////////////////////////////////////////
	// Video sync
	////////////////////////////////////////

	sync_fix u_fix_h (
		.clk    (clk),
		.resetd (resetd),
		.i_sync (i_sync.hs),
		.o_sync (hs_fixed)
	);

	sync_fix u_fix_v (
		.clk    (clk),
		.resetd (resetd),
		.i_sync (i_sync.vs),
		.o_sync (vs_fixed)
	);

	assign sync_fixed = '{hs: hs_fixed, vs: vs_fixed};

	csync_gen u_csync (
		.clk        (clk),
		.resetd     (resetd),
		.i_sync     (sync_fixed),
		.i_csync_en (csync_en),
		.o_sync     (o_sync)
	);

endmodule

// File: verilog/csync_gen.sv
// Expects active-high sync with the short phase high; composite needs one full line measured first
`timescale 1ns/1ps
`include "sys_io_defines.svh"

module csync_gen (
	input  logic              clk,
	input  logic              resetd,
	input  sys_io_pkg::sync_t i_sync,
	input  logic              i_csync_en,
	output sys_io_pkg::sync_t o_sync
);
	logic                   hs_prev;
	logic                   hs_rise;
	logic                   hs_fall;
	logic [`LINE_CNT_W-1:0] h_cnt;
	logic [`LINE_CNT_W-1:0] run;
	logic [`LINE_CNT_W-1:0] hs_len;
	logic [`LINE_CNT_W-1:0] line_len;
	logic                   cs_q;
	logic                   cs_now;

	assign hs_rise = i_sync.hs & ~hs_prev;
	assign hs_fall = ~i_sync.hs & hs_prev;
	assign run     = h_cnt + 1'b1;

	// Pulse starts one hsync width before the line boundary and ends on it
	always_comb begin
		cs_now = cs_q;
		if (hs_rise) begin
			cs_now = 1'b0;
		end else if (~i_sync.hs & ~hs_prev & (run == line_len)) begin
			cs_now = 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (resetd) begin
			hs_prev  <= 1'b0;
			h_cnt    <= '0;
			hs_len   <= '0;
			line_len <= '0;
			cs_q     <= 1'b0;
			o_sync   <= '0;
		end else begin
			hs_prev <= i_sync.hs;

			// Line and pulse measurement
			if (hs_rise | hs_fall) begin
				h_cnt <= '0;
			end else if (~&h_cnt) begin
				h_cnt <= h_cnt + 1'b1;
			end
			if (hs_fall) begin
				hs_len <= run;
			end
			if (hs_rise) begin
				line_len <= run - hs_len;
			end

			cs_q <= i_sync.vs ? cs_now : 1'b0;

			o_sync.hs <= (i_sync.vs & i_csync_en) ? cs_now : i_sync.hs;
			o_sync.vs <= i_sync.vs;
		end
	end

endmodule

// File: verilog/sync_fix.sv
// Polarity follows the last measured runs, so the first full period after reset may pass inverted
`timescale 1ns/1ps
`include "sys_io_defines.svh"

module sync_fix (
	input  logic clk,
	input  logic resetd,
	input  logic i_sync,
	output logic o_sync
);
	logic                   s1;
	logic                   s2;
	logic [`SYNC_CNT_W-1:0] run_cnt;
	logic [`SYNC_CNT_W-1:0] high_len;
	logic [`SYNC_CNT_W-1:0] low_len;
	logic                   invert;

	// Short phase always comes out high
	assign o_sync = i_sync ^ invert;

	always_ff @(posedge clk) begin
		if (resetd) begin
			s1       <= 1'b0;
			s2       <= 1'b0;
			run_cnt  <= '0;
			high_len <= '0;
			low_len  <= '0;
			invert   <= 1'b0;
		end else begin
			s1 <= i_sync;
			s2 <= s1;

			// Counter saturates on a stuck input
			if (s1 != s2) begin
				run_cnt <= '0;
			end else if (~&run_cnt) begin
				run_cnt <= run_cnt + 1'b1;
			end

			if (s1 & ~s2) begin
				low_len <= run_cnt;
			end
			if (~s1 & s2) begin
				high_len <= run_cnt;
			end

			invert <= high_len > low_len;
		end
	end

endmodule

// File: verilog/aud_mix.sv
// Core samples must hold for 2 clk to pass the stabilizer; the output settles 7 clk after that
`timescale 1ns/1ps
`include "sys_io_defines.svh"

module aud_mix (
	input  logic              clk,
	input  logic              resetd,
	input  logic [`AUD_W-1:0] i_core,
	input  logic [`AUD_W-1:0] i_pcm,
	input  logic [`AUD_W-1:0] i_pre,
	input  logic [1:0]        i_mix,
	input  logic              i_signed,
	input  logic [`ATT_W-1:0] i_att,
	output logic [`AUD_W-1:0] o_pre,
	output logic [`AUD_W-1:0] o_out
);
	// One guard bit above the sample
	localparam int SUM_W = `AUD_W + 1;

	logic [`AUD_W-1:0]       core_s1;
	logic [`AUD_W-1:0]       core_s2;
	logic [`AUD_W-1:0]       core_st;
	logic signed [SUM_W-1:0] core_ext;
	logic signed [SUM_W-1:0] pcm_ext;
	logic signed [SUM_W-1:0] pre_ext;
	logic signed [SUM_W-1:0] sum_q;
	logic signed [SUM_W-1:0] blend_q;
	logic signed [SUM_W-1:0] att_q;

	// Stabilizer, a sample passes once seen twice in a row
	always_ff @(posedge clk) begin
		core_s1 <= i_core;
		core_s2 <= core_s1;
	end

	// Unsigned core audio is halved into the signed range
	assign core_ext = i_signed ? $signed({core_st[`AUD_W-1], core_st})
	                           : $signed({2'b00, core_st[`AUD_W-1:1]});
	assign pcm_ext  = $signed({i_pcm[`AUD_W-1], i_pcm});
	assign pre_ext  = $signed({i_pre[`AUD_W-1], i_pre});

	// Halved sum for the other channel
	assign o_pre = sum_q[SUM_W-1:1];

	always_ff @(posedge clk) begin
		if (resetd) begin
			core_st <= '0;
			sum_q   <= '0;
			blend_q <= '0;
			att_q   <= '0;
			o_out   <= '0;
		end else begin
			if (core_s1 == core_s2) begin
				core_st <= core_s2;
			end

			sum_q <= core_ext + pcm_ext;

			// Stereo blend
			case (i_mix)
				2'd0: blend_q <= sum_q;
				2'd1: blend_q <= sum_q - (sum_q >>> 3) + (pre_ext >>> 2);
				2'd2: blend_q <= sum_q - (sum_q >>> 2) + (pre_ext >>> 1);
				default: blend_q <= (sum_q >>> 1) + pre_ext;
			endcase

			if (i_att[`ATT_W-1]) begin
				att_q <= '0;
			end else begin
				att_q <= blend_q >>> i_att[`ATT_W-2:0];
			end

			// Saturate to the sample range
			if (att_q[SUM_W-1] ^ att_q[SUM_W-2]) begin
				o_out <= {att_q[SUM_W-1], {(`AUD_W-1){att_q[SUM_W-2]}}};
			end else begin
				o_out <= att_q[`AUD_W-1:0];
			end
		end
	end

endmodule

// File: verilog/cmd_decoder.sv
// Bus levels are resampled on clk, so strobe high and low phases must each last at least 1 clk
`timescale 1ns/1ps
`include "sys_io_defines.svh"

module cmd_decoder (
	input  logic                      clk,
	input  logic                      resetd,
	input  sys_io_pkg::io_bus_t       i_io,
	input  sys_io_pkg::status_led_t   i_status,
	output sys_io_pkg::cfg_word_t     o_cfg,
	output logic                      o_csync_en,
	output logic [`ATT_W-1:0]         o_att,
	output logic [7:0]                o_led
);
	import sys_io_pkg::*;

	logic              sel_q;
	logic              strobe_q;
	logic              strobe_qq;
	logic [`IO_W-1:0]  din_q;
	logic              strobe_rise;
	io_word_u          word;
	logic              has_cmd;
	logic [7:0]        cmd;
	cfg_word_t         cfg_q;
	led_word_t         led_q;
	logic [`ATT_W-1:0] att_q;
	logic [7:0]        led_dflt;

	////////////////////////////////////////
	// Bus sampling
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (resetd) begin
			sel_q     <= 1'b0;
			strobe_q  <= 1'b0;
			strobe_qq <= 1'b0;
		end else begin
			sel_q     <= i_io.sel_uio;
			strobe_q  <= i_io.strobe;
			strobe_qq <= strobe_q;
		end
	end

	// Data word travels with the sampled strobe
	always_ff @(posedge clk) begin
		din_q <= i_io.din;
	end

	assign strobe_rise = strobe_q & ~strobe_qq;
	assign word        = din_q;

	////////////////////////////////////////
	// Command and register writes
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (resetd) begin
			has_cmd <= 1'b0;
			cmd     <= '0;
			cfg_q   <= '0;
			led_q   <= '0;
			att_q   <= '0;
		end else if (!sel_q) begin
			// Select dropped, next word is a new command
			has_cmd <= 1'b0;
			cmd     <= '0;
		end else if (strobe_rise) begin
			if (!has_cmd) begin
				has_cmd <= 1'b1;
				cmd     <= din_q[7:0];
			end else begin
				case (cmd)
					`CMD_CFG: cfg_q <= word.cfg;
					`CMD_LED: led_q <= word.led;
					`CMD_VOL: att_q <= din_q[`ATT_W-1:0];
					default: ;
				endcase
			end
		end
	end

	////////////////////////////////////////
	// LED composition
	////////////////////////////////////////

	// Default pattern from core status
	assign led_dflt = {3'b000, &i_status.power, 1'b0, i_status.disk[0], 1'b0, i_status.user};

	assign o_led = (led_q.overtake & led_q.state) | (~led_q.overtake & led_dflt);

	assign o_cfg      = cfg_q;
	assign o_csync_en = cfg_q.csync_en;
	assign o_att      = att_q;

endmodule

// File: verilog/sys_io_pkg.sv
// Field layouts match the host firmware word formats; reserved bits are stored but never decoded
`include "sys_io_defines.svh"

package sys_io_pkg;

	// Host bus, levels sampled on clk
	typedef struct packed {
		logic             sel_uio;
		logic             strobe;
		logic [`IO_W-1:0] din;
	} io_bus_t;

	// Configuration word of command 01h
	typedef struct packed {
		logic [2:0] rsv_15_13;
		logic       vga_fb;
		logic       limited_hi;
		logic       direct_video;
		logic       rsv_9;
		logic       limited_lo;
		logic       dvi_mode;
		logic       audio_96k;
		logic       ypbpr_en;
		logic       rsv_4;
		logic       csync_en;
		logic [2:0] rsv_2_0;
	} cfg_word_t;

	// LED override word of command 25h
	typedef struct packed {
		logic [7:0] overtake;
		logic [7:0] state;
	} led_word_t;

	// Same data word, decoded by the current command
	typedef union packed {
		cfg_word_t cfg;
		led_word_t led;
	} io_word_u;

	typedef struct packed {
		logic [`AUD_W-1:0] l;
		logic [`AUD_W-1:0] r;
	} audio_pair_t;

	typedef struct packed {
		logic hs;
		logic vs;
	} sync_t;

	// Status LEDs from the core
	typedef struct packed {
		logic       user;
		logic [1:0] power;
		logic [1:0] disk;
	} status_led_t;

endpackage

// File: verilog/sys_io_defines.svh
// Widths are fixed for a 16-bit host bus and 16-bit audio; changing them needs matching stimulus
`ifndef SYS_IO_DEFINES_SVH
`define SYS_IO_DEFINES_SVH

////////////////////////////////////////
// Datapath widths
////////////////////////////////////////

// Audio sample
`define AUD_W 16

// Host data word
`define IO_W 16

// Attenuation field, top bit is mute
`define ATT_W 5

// Run counters for the sync path
`define SYNC_CNT_W 16
`define LINE_CNT_W 16

////////////////////////////////////////
// Host command codes
////////////////////////////////////////

`define CMD_CFG 8'h01
`define CMD_LED 8'h25
`define CMD_VOL 8'h26

`endif
